// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_icache \
		--Mdir obj_dir -o tb_icache
	./obj_dir/tb_icache | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
rtl/icache_pkg.sv
rtl/simple_dpram.sv
rtl/cache_lru.sv
rtl/line_fetch.sv
rtl/icache.sv
rtl/icache_top.sv
sim/tb_icache.sv

// ==== rtl/cache_lru.sv ====
module cache_lru #(
    parameter int  NUMWAYS    = 2,
    localparam int HIST_WIDTH = NUMWAYS * (NUMWAYS - 1) / 2
) (
    input  logic [HIST_WIDTH-1:0] current_i,
    input  logic [NUMWAYS-1:0]    access_i,
    output logic [HIST_WIDTH-1:0] update_o,
    output logic [NUMWAYS-1:0]    lru_pre_o
);

    // older[i][j] set: way i was used less recently than way j
    // Diagonal stays set so a row reduction works
    logic [NUMWAYS-1:0][NUMWAYS-1:0] older;

    // One history bit per way pair (i < j), bit set when i is older
    always_comb begin
        int k;
        older    = '1;
        update_o = current_i;
        k        = 0;
        for (int i = 0; i < NUMWAYS; i++) begin
            for (int j = i + 1; j < NUMWAYS; j++) begin
                older[i][j] = current_i[k];
                older[j][i] = !current_i[k];
                // Accessed way becomes the most recent of the pair
                if (access_i[i]) begin
                    update_o[k] = 1'b0;
                end else if (access_i[j]) begin
                    update_o[k] = 1'b1;
                end
                k++;
            end
        end
    end

    // Victim is the way older than every other way
    always_comb begin
        for (int i = 0; i < NUMWAYS; i++) begin
            lru_pre_o[i] = &older[i];
        end
    end

    // Hit vector and saved victim from the cache must never name two ways
    always_comb begin
        a_access_onehot : assert ($onehot0(access_i))
            else $error("cache_lru: access vector %b is not one-hot", access_i);
    end

endmodule

// ==== rtl/icache.sv ====
module icache #(
    parameter int WAYS      = 2,
    parameter int SET_WIDTH = 9
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] cpu_adr_i,
    output logic                              cpu_ack_o,
    output logic [icache_pkg::INSN_WIDTH-1:0] cpu_dat_o,
    output logic                              cpu_err_o,
    input  logic                              spr_stb_i,
    input  logic                              spr_we_i,
    input  logic [15:0]                       spr_addr_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] spr_dat_i,
    output logic                              spr_ack_o,
    output logic                              refill_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] refill_adr_o,
    input  logic                              line_we_i,
    input  logic [icache_pkg::LINE_BITS-1:0]  line_dat_i,
    input  logic                              line_err_i
);

    // Byte offset within a line, fixed by the bus line size
    localparam int BLOCK_WIDTH = $clog2(icache_pkg::LINE_BITS / 8);
    localparam int WAY_WIDTH   = SET_WIDTH + BLOCK_WIDTH;
    localparam int TAG_WIDTH   = icache_pkg::ADDR_WIDTH - WAY_WIDTH;
    localparam int LRU_WIDTH   = WAYS * (WAYS - 1) / 2;
    localparam int WORD_BITS   = $clog2(icache_pkg::BEATS);

    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [icache_pkg::LINE_BITS-1:0] line_t;

    // Tag entry: LRU history on top, then valid bits, then one tag per way
    typedef struct packed {
        logic [LRU_WIDTH-1:0] lru;
        logic [WAYS-1:0]      valid;
        tag_t [WAYS-1:0]      tag;
    } tag_entry_t;

    icache_pkg::cache_state_t state;

    // Lookup address, registered with the RAM read
    logic [icache_pkg::ADDR_WIDTH-1:0] lookup_adr;
    logic [SET_WIDTH-1:0]              lookup_set;
    tag_t                              lookup_tag;
    logic [WORD_BITS-1:0]              word_sel;
    logic [SET_WIDTH-1:0]              rd_set;
    logic [SET_WIDTH-1:0]              inv_set;

    tag_entry_t           tag_dout;
    tag_entry_t           tag_din;
    tag_entry_t           tag_save;
    logic                 tag_we;
    logic [SET_WIDTH-1:0] tag_waddr;

    line_t           way_dout [WAYS];
    logic [WAYS-1:0] way_we;
    logic [WAYS-1:0] way_hit;
    logic            hit;

    logic [WAYS-1:0]      lru_pre;
    logic [WAYS-1:0]      victim;
    logic [WAYS-1:0]      access;
    logic [LRU_WIDTH-1:0] lru_current;
    logic [LRU_WIDTH-1:0] lru_next;

    logic spr_icbir;
    logic inv_take;

    assign rd_set     = cpu_adr_i[WAY_WIDTH-1:BLOCK_WIDTH];
    assign lookup_set = lookup_adr[WAY_WIDTH-1:BLOCK_WIDTH];
    assign lookup_tag = lookup_adr[icache_pkg::ADDR_WIDTH-1:WAY_WIDTH];
    assign word_sel   = lookup_adr[BLOCK_WIDTH-1:2];

    // Refill line address, held for the whole REFILL state
    assign refill_req_o = (state == icache_pkg::REFILL);
    assign refill_adr_o = {lookup_adr[icache_pkg::ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};

    // Tag compare against every way
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = tag_dout.valid[w] && (tag_dout.tag[w] == lookup_tag);
        end
    end

    assign hit       = |way_hit;
    assign cpu_ack_o = (state == icache_pkg::READ) && hit;
    assign cpu_err_o = (state == icache_pkg::REFILL) && line_err_i;

    // Hitting way onto the data port, then word by address bits 4 to 2
    always_comb begin
        line_t sel_line;
        sel_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            sel_line = sel_line | (way_dout[w] & {icache_pkg::LINE_BITS{way_hit[w]}});
        end
        cpu_dat_o = sel_line[word_sel*icache_pkg::INSN_WIDTH +: icache_pkg::INSN_WIDTH];
    end

    // Invalidate waits while a refill owns the tag memory
    assign spr_icbir = spr_stb_i && spr_we_i && (spr_addr_i == icache_pkg::SPR_ICBIR_ADDR);
    assign inv_take  = spr_icbir && (state != icache_pkg::REFILL) &&
                       (state != icache_pkg::INVALIDATE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= icache_pkg::IDLE;
            spr_ack_o <= 1'b0;
        end else begin
            // Other SPR accesses have no effect here, ack them right away
            spr_ack_o <= inv_take || (spr_stb_i && !spr_icbir && !spr_ack_o);
            case (state)
                icache_pkg::IDLE: begin
                    if (cpu_req_i) begin
                        state <= icache_pkg::READ;
                    end
                end
                icache_pkg::READ: begin
                    // Stay in READ when the next address follows the ack
                    if (!hit) begin
                        state <= icache_pkg::REFILL;
                    end else if (!cpu_req_i) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                icache_pkg::REFILL: begin
                    if (line_we_i || line_err_i) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
            if (inv_take) begin
                state <= icache_pkg::INVALIDATE;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Miss address stays put during refill
        if (state != icache_pkg::REFILL) begin
            lookup_adr <= cpu_adr_i;
        end
        // Victim and old entry kept for the tag write after the fill
        if ((state == icache_pkg::READ) && !hit) begin
            tag_save <= tag_dout;
            victim   <= lru_pre;
        end
        if (inv_take) begin
            inv_set <= spr_dat_i[WAY_WIDTH-1:BLOCK_WIDTH];
        end
    end

    // LRU access: the hitting way, or the filled way
    always_comb begin
        access = '0;
        if ((state == icache_pkg::READ) && hit) begin
            access = way_hit;
        end else if ((state == icache_pkg::REFILL) && line_we_i) begin
            access = victim;
        end
    end

    assign lru_current = (state == icache_pkg::REFILL) ? tag_save.lru : tag_dout.lru;
    assign tag_waddr   = (state == icache_pkg::INVALIDATE) ? inv_set : lookup_set;

    // Tag and way write control
    always_comb begin
        tag_din = tag_dout;
        tag_we  = 1'b0;
        way_we  = '0;
        case (state)
            icache_pkg::READ: begin
                // Hit only refreshes the history
                if (hit) begin
                    tag_din.lru = lru_next;
                    tag_we      = 1'b1;
                end
            end
            icache_pkg::REFILL: begin
                if (line_we_i) begin
                    way_we  = victim;
                    tag_din = tag_save;
                    for (int w = 0; w < WAYS; w++) begin
                        if (victim[w]) begin
                            tag_din.valid[w] = 1'b1;
                            tag_din.tag[w]   = lookup_tag;
                        end
                    end
                    tag_din.lru = lru_next;
                    tag_we      = 1'b1;
                end
            end
            icache_pkg::INVALIDATE: begin
                // Whole set cleared, history too
                tag_din = '0;
                tag_we  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    simple_dpram #(
        .SET_WIDTH(SET_WIDTH),
        .data_t   (tag_entry_t)
    ) u_tag_ram (
        .clk    (clk),
        .raddr_i(rd_set),
        .waddr_i(tag_waddr),
        .we_i   (tag_we),
        .din_i  (tag_din),
        .dout_o (tag_dout)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        simple_dpram #(
            .SET_WIDTH(SET_WIDTH),
            .data_t   (line_t)
        ) u_way_ram (
            .clk    (clk),
            .raddr_i(rd_set),
            .waddr_i(lookup_set),
            .we_i   (way_we[w]),
            .din_i  (line_dat_i),
            .dout_o (way_dout[w])
        );
    end

    cache_lru #(
        .NUMWAYS(WAYS)
    ) u_lru (
        .current_i(lru_current),
        .access_i (access),
        .update_o (lru_next),
        .lru_pre_o(lru_pre)
    );

    // A line is filled only on a miss, so no two ways hold the same tag
    a_way_hit_onehot : assert property (@(posedge clk) disable iff (rst)
        (state == icache_pkg::READ) |-> $onehot0(way_hit));

    // Fill pulses arrive only while the cache waits in REFILL, never during an invalidate
    a_fill_in_refill : assert property (@(posedge clk) disable iff (rst)
        (line_we_i || line_err_i) |-> (state == icache_pkg::REFILL));

endmodule

// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    // Fetch address width, also bounds the cached tag
    localparam int ADDR_WIDTH = 32;

    // One instruction word per fetch
    localparam int INSN_WIDTH = 32;

    // Refill line of 32 bytes
    localparam int LINE_BITS = 256;

    // Bus words per line
    localparam int BEATS = LINE_BITS / INSN_WIDTH;

    // Block invalidate register, IC group 4, register 2
    localparam logic [15:0] SPR_ICBIR_ADDR = 16'h2002;

    // Cache controller states
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        READ       = 2'd1,
        REFILL     = 2'd2,
        INVALIDATE = 2'd3
    } cache_state_t;

endpackage

// ==== rtl/icache_top.sv ====
module icache_top #(
    parameter int WAYS      = 2,
    parameter int SET_WIDTH = 9
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] cpu_adr_i,
    output logic                              cpu_ack_o,
    output logic [icache_pkg::INSN_WIDTH-1:0] cpu_dat_o,
    output logic                              cpu_err_o,
    input  logic                              spr_stb_i,
    input  logic                              spr_we_i,
    input  logic [15:0]                       spr_addr_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] spr_dat_i,
    output logic                              spr_ack_o,
    output logic                              mem_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_adr_o,
    input  logic                              mem_ack_i,
    input  logic [icache_pkg::INSN_WIDTH-1:0] mem_dat_i,
    input  logic                              mem_err_i
);

    // Refill path between cache and fetch unit
    logic                              refill_req;
    logic [icache_pkg::ADDR_WIDTH-1:0] refill_adr;
    logic                              line_we;
    logic [icache_pkg::LINE_BITS-1:0]  line_dat;
    logic                              line_err;

    icache #(
        .WAYS     (WAYS),
        .SET_WIDTH(SET_WIDTH)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .cpu_adr_i   (cpu_adr_i),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_dat_o   (cpu_dat_o),
        .cpu_err_o   (cpu_err_o),
        .spr_stb_i   (spr_stb_i),
        .spr_we_i    (spr_we_i),
        .spr_addr_i  (spr_addr_i),
        .spr_dat_i   (spr_dat_i),
        .spr_ack_o   (spr_ack_o),
        .refill_req_o(refill_req),
        .refill_adr_o(refill_adr),
        .line_we_i   (line_we),
        .line_dat_i  (line_dat),
        .line_err_i  (line_err)
    );

    line_fetch u_line_fetch (
        .clk         (clk),
        .rst         (rst),
        .refill_req_i(refill_req),
        .refill_adr_i(refill_adr),
        .line_we_o   (line_we),
        .line_dat_o  (line_dat),
        .line_err_o  (line_err),
        .mem_req_o   (mem_req_o),
        .mem_adr_o   (mem_adr_o),
        .mem_ack_i   (mem_ack_i),
        .mem_dat_i   (mem_dat_i),
        .mem_err_i   (mem_err_i)
    );

endmodule

// ==== rtl/line_fetch.sv ====
module line_fetch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              refill_req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] refill_adr_i,
    output logic                              line_we_o,
    output logic [icache_pkg::LINE_BITS-1:0]  line_dat_o,
    output logic                              line_err_o,
    output logic                              mem_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_adr_o,
    input  logic                              mem_ack_i,
    input  logic [icache_pkg::INSN_WIDTH-1:0] mem_dat_i,
    input  logic                              mem_err_i
);

    localparam int CNT_WIDTH = $clog2(icache_pkg::BEATS);

    logic [CNT_WIDTH-1:0] beat;
    logic                 start;
    logic                 last_beat;
    logic                 beat_ack;

    // Request level still high in the pulse cycle, must not restart
    assign start     = refill_req_i && !mem_req_o && !line_we_o && !line_err_o;
    assign last_beat = (beat == CNT_WIDTH'(icache_pkg::BEATS - 1));
    assign beat_ack  = mem_req_o && mem_ack_i && !mem_err_i;

    // mem_req_o doubles as the busy flag
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_o  <= 1'b0;
            beat       <= '0;
            line_we_o  <= 1'b0;
            line_err_o <= 1'b0;
        end else begin
            line_we_o  <= 1'b0;
            line_err_o <= 1'b0;
            if (start) begin
                mem_req_o <= 1'b1;
                beat      <= '0;
            end else if (mem_req_o) begin
                if (mem_err_i) begin
                    // Error aborts the fill, partial line dropped
                    mem_req_o  <= 1'b0;
                    line_err_o <= 1'b1;
                end else if (mem_ack_i) begin
                    beat <= beat + 1'b1;
                    if (last_beat) begin
                        mem_req_o <= 1'b0;
                        line_we_o <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_adr_o <= refill_adr_i;
        end else if (beat_ack) begin
            mem_adr_o <= mem_adr_o + 4;
        end
        // Shift down, so word 0 ends up in the low bits after eight beats
        if (beat_ack) begin
            line_dat_o <= {mem_dat_i, line_dat_o[icache_pkg::LINE_BITS-1:icache_pkg::INSN_WIDTH]};
        end
    end

    // Address held until the slave answers
    a_adr_stable : assert property (@(posedge clk) disable iff (rst)
        (mem_req_o && !mem_ack_i && !mem_err_i) |=> (mem_req_o && $stable(mem_adr_o)));

endmodule

// ==== rtl/simple_dpram.sv ====
module simple_dpram #(
    parameter int  SET_WIDTH = 9,
    parameter type data_t    = logic [31:0]
) (
    input  logic                 clk,
    input  logic [SET_WIDTH-1:0] raddr_i,
    input  logic [SET_WIDTH-1:0] waddr_i,
    input  logic                 we_i,
    input  data_t                din_i,
    output data_t                dout_o
);

    // One entry per set
    data_t mem [2**SET_WIDTH];

    // Read port registered every cycle
    // A read of the address being written returns the old entry
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= din_i;
        end
        dout_o <= mem[raddr_i];
    end

endmodule

// ==== sim/tb_icache.sv ====
module tb_icache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAYS         = 2;
    localparam int SET_WIDTH    = 4;
    localparam int SETS         = 2**SET_WIDTH;
    localparam int CLK_PERIOD   = 8;
    localparam int MEM_WORDS    = 1024;
    // Flush, random fetches and the directed fetches, with some margin
    localparam int NUM_ACCESSES = 240;

    logic        clk;
    logic        rst;
    logic        cpu_req_i;
    logic [31:0] cpu_adr_i;
    logic        cpu_ack_o;
    logic [31:0] cpu_dat_o;
    logic        cpu_err_o;
    logic        spr_stb_i;
    logic        spr_we_i;
    logic [15:0] spr_addr_i;
    logic [31:0] spr_dat_i;
    logic        spr_ack_o;
    logic        mem_req_o;
    logic [31:0] mem_adr_o;
    logic        mem_ack_i;
    logic [31:0] mem_dat_i;
    logic        mem_err_i;

    // Memory image, each word a hash of its byte address
    logic [31:0] mem [MEM_WORDS];

    // Cache model: two entries per set and the way that goes next
    logic [31:0] m_tag [SETS][2];
    bit          m_valid [SETS][2];
    int          m_lru [SETS];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int fill_count;
    bit err_armed;
    int err_beat;

    icache_top #(
        .WAYS     (WAYS),
        .SET_WIDTH(SET_WIDTH)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (cpu_req_i),
        .cpu_adr_i (cpu_adr_i),
        .cpu_ack_o (cpu_ack_o),
        .cpu_dat_o (cpu_dat_o),
        .cpu_err_o (cpu_err_o),
        .spr_stb_i (spr_stb_i),
        .spr_we_i  (spr_we_i),
        .spr_addr_i(spr_addr_i),
        .spr_dat_i (spr_dat_i),
        .spr_ack_o (spr_ack_o),
        .mem_req_o (mem_req_o),
        .mem_adr_o (mem_adr_o),
        .mem_ack_i (mem_ack_i),
        .mem_dat_i (mem_dat_i),
        .mem_err_i (mem_err_i)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] word_hash(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic int set_of(input logic [31:0] adr);
        return int'(adr[SET_WIDTH+4:5]);
    endfunction

    // Way holding the line, or -1 on a miss
    function automatic int model_way(input logic [31:0] adr);
        int s;
        s = set_of(adr);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[s][w] && (m_tag[s][w] == (adr >> (SET_WIDTH + 5)))) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Hit makes the way most recent, a fill replaces the least recent
    task automatic model_access(input logic [31:0] adr, input int way);
        int s;
        int w;
        s = set_of(adr);
        w = way;
        if (w < 0) begin
            w = m_lru[s];
            m_tag[s][w]   = adr >> (SET_WIDTH + 5);
            m_valid[s][w] = 1'b1;
        end
        m_lru[s] = 1 - w;
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs_low();
        check_equal("cpu_ack_o", 32'(cpu_ack_o), 32'd0);
        check_equal("cpu_err_o", 32'(cpu_err_o), 32'd0);
        check_equal("spr_ack_o", 32'(spr_ack_o), 32'd0);
        check_equal("mem_req_o", 32'(mem_req_o), 32'd0);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
        end
        $display("test %-10s finished, %0d errors", name, errors - errors_before);
    endtask

    // One fetch, request held until ack or error, then one idle cycle
    task automatic fetch(input logic [31:0] adr, input bit inject_err, input int beat,
                         output bit acked, output bit errored, output bit missed);
        int way;
        int starts;
        way        = model_way(adr);
        starts     = fill_count;
        err_armed  = inject_err;
        err_beat   = beat;
        acked      = 1'b0;
        errored    = 1'b0;
        cpu_adr_i  = adr;
        cpu_req_i  = 1'b1;
        while (!acked && !errored) begin
            @(negedge clk);
            acked   = cpu_ack_o;
            errored = cpu_err_o;
        end
        cpu_req_i = 1'b0;
        err_armed = 1'b0;
        // A memory request before the answer means the model must predict a miss
        missed = (fill_count != starts);
        check_equal("mem_req_o", 32'(missed), 32'(way < 0));
        if (acked) begin
            model_access(adr, way);
        end
        @(negedge clk);
    endtask

    task automatic fetch_expect(input logic [31:0] adr, input bit exp_miss);
        bit acked;
        bit errored;
        bit missed;
        fetch(adr, 1'b0, 0, acked, errored, missed);
        check_equal("cpu_ack_o", 32'(acked), 32'd1);
        check_equal("mem_req_o", 32'(missed), 32'(exp_miss));
    endtask

    // Block invalidate through the SPR port, strobe held until ack
    task automatic invalidate(input logic [31:0] adr);
        int waited;
        int s;
        spr_stb_i  = 1'b1;
        spr_we_i   = 1'b1;
        spr_addr_i = icache_pkg::SPR_ICBIR_ADDR;
        spr_dat_i  = adr;
        waited     = 0;
        while (!spr_ack_o && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        check_equal("spr_ack_o", 32'(spr_ack_o), 32'd1);
        spr_stb_i = 1'b0;
        spr_we_i  = 1'b0;
        s = set_of(adr);
        m_valid[s][0] = 1'b0;
        m_valid[s][1] = 1'b0;
        m_lru[s]      = 0;
        @(negedge clk);
    endtask

    // Memory slave: 0 to 3 idle cycles per beat, optional error on one beat
    initial begin
        int wait_cycles;
        int beat_idx;
        bit req_seen;
        mem_ack_i   = 1'b0;
        mem_err_i   = 1'b0;
        mem_dat_i   = '0;
        fill_count  = 0;
        wait_cycles = 0;
        beat_idx    = 0;
        req_seen    = 1'b0;
        forever begin
            @(negedge clk);
            mem_ack_i = 1'b0;
            mem_err_i = 1'b0;
            if (mem_req_o && !req_seen) begin
                fill_count++;
                beat_idx = 0;
            end
            req_seen = mem_req_o;
            if (mem_req_o) begin
                if (wait_cycles > 0) begin
                    wait_cycles--;
                end else begin
                    // Beats walk the missed line upward from its first word
                    check_equal("mem_adr_o", mem_adr_o,
                                {cpu_adr_i[31:5], 5'd0} | (32'(beat_idx) << 2));
                    if (err_armed && (mem_adr_o[4:2] == 3'(err_beat))) begin
                        mem_err_i = 1'b1;
                        err_armed = 1'b0;
                    end else begin
                        mem_ack_i = 1'b1;
                        mem_dat_i = mem[mem_adr_o[11:2]];
                        beat_idx++;
                    end
                    wait_cycles = int'($urandom_range(0, 3));
                end
            end
        end
    end

    // Every ack cycle carries the memory word of the held address
    always @(negedge clk) begin
        if (!rst && cpu_ack_o) begin
            check_equal("cpu_dat_o", cpu_dat_o, mem[cpu_adr_i[11:2]]);
        end
    end

    initial begin
        #(NUM_ACCESSES * 40 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NUM_ACCESSES * 40);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int          base;
        bit          acked;
        bit          errored;
        bit          missed;
        logic [31:0] adr;
        void'($urandom(37));
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_armed    = 1'b0;
        err_beat     = 0;
        rst          = 1'b1;
        cpu_req_i    = 1'b0;
        cpu_adr_i    = '0;
        spr_stb_i    = 1'b0;
        spr_we_i     = 1'b0;
        spr_addr_i   = '0;
        spr_dat_i    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_hash(32'(i) << 2);
        end

        // Outputs quiet through reset and one cycle after
        base = errors;
        repeat (5) begin
            @(negedge clk);
            check_outputs_low();
        end
        rst = 1'b0;
        @(negedge clk);
        check_outputs_low();
        end_test("reset", base);

        // Tag memory starts unknown, clear every set
        base = errors;
        for (int s = 0; s < SETS; s++) begin
            invalidate(32'(s) << 5);
        end
        end_test("flush", base);

        base = errors;
        for (int n = 0; n < 200; n++) begin
            adr = 32'($urandom_range(0, 255)) << 2;
            fetch(adr, 1'b0, 0, acked, errored, missed);
            check_equal("cpu_ack_o", 32'(acked), 32'd1);
        end
        end_test("data", base);

        // Fresh fill of one line, then the same line again without a second fill
        base = errors;
        invalidate(32'h0000_01E0);
        fetch_expect(32'h0000_01E0, 1'b1);
        fetch_expect(32'h0000_01E4, 1'b0);
        end_test("hit_miss", base);

        // A, B, A, C in set 5, C evicts B
        base = errors;
        invalidate(32'h0000_00A0);
        fetch_expect(32'h0000_00A0, 1'b1);
        fetch_expect(32'h0000_02A0, 1'b1);
        fetch_expect(32'h0000_00A4, 1'b0);
        fetch_expect(32'h0000_04A0, 1'b1);
        fetch_expect(32'h0000_00A8, 1'b0);
        fetch_expect(32'h0000_02AC, 1'b1);
        end_test("lru", base);

        // Both lines of set 10 dropped by one invalidate
        base = errors;
        fetch_expect(32'h0000_0140, model_way(32'h0000_0140) < 0);
        fetch_expect(32'h0000_0340, model_way(32'h0000_0340) < 0);
        fetch_expect(32'h0000_0144, 1'b0);
        invalidate(32'h0000_0140);
        fetch_expect(32'h0000_0348, 1'b1);
        fetch_expect(32'h0000_0140, 1'b1);
        end_test("invalidate", base);

        // Error on beat 3 aborts the fill, the retry succeeds
        base = errors;
        fetch(32'h0000_0810, 1'b1, 3, acked, errored, missed);
        check_equal("cpu_err_o", 32'(errored), 32'd1);
        check_equal("cpu_ack_o", 32'(acked), 32'd0);
        fetch_expect(32'h0000_0810, 1'b1);
        end_test("bus_error", base);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
